//--- Bender.yml
package:
  name: ddc_rx

export_include_dirs:
  - include

sources:
  - design/nco_pkg.sv
  - design/stream_pkg.sv
  - design/phase_accumulator.sv
  - design/adc_capture.sv
  - design/cordic_rotator.sv
  - design/sample_fifo.sv
  - design/fx2_writer.sv
  - design/ddc_top.sv
  - target: test
    files:
      - tests/ddc_props.sv
      - tests/ddc_tb.sv

//--- design/adc_capture.sv
`timescale 1ns/10ps

module adc_capture (
	input logic ENC_CLK,
	input logic rst,
	input stream_pkg::sample_t da,
	input stream_pkg::fifo_status_t status,
	output stream_pkg::sample_beat_t beat
);

	stream_pkg::sample_t da_q;
	logic gate_q;

	// adc word buffered every cycle
	always_ff @(posedge ENC_CLK) begin
		da_q <= da;
	end

	// hysteresis: open on empty, close on full
	always_ff @(posedge ENC_CLK) begin
		if (rst) begin
			gate_q <= 1'b0;
		end else if (status.full) begin
			gate_q <= 1'b0; // full wins
		end else if (status.empty) begin
			gate_q <= 1'b1;
		end
	end

	always_comb begin
		beat.data = da_q;
		beat.valid = gate_q; // level, not a pulse
	end

endmodule

//--- design/cordic_rotator.sv
`timescale 1ns/10ps
`include "nco_settings.svh"

module cordic_rotator (
	input logic ENC_CLK,
	input logic rst,
	input stream_pkg::sample_beat_t beat,
	input nco_pkg::phase_t phase,
	output stream_pkg::sample_beat_t result
);

	localparam int N = `CORDIC_STAGES;
	localparam int W = `CORDIC_XY_W;
	localparam int PW = `CORDIC_PHASE_W;

	// atan(2^-i), 2^16 per turn
	localparam logic [PW-1:0] ATAN [N] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651, 16'd326, 16'd163, 16'd81,
		16'd41, 16'd20, 16'd10, 16'd5,
		16'd3, 16'd1, 16'd1, 16'd0
	};

	nco_pkg::cordic_phase_t angle;
	nco_pkg::cordic_stage_t pre;
	nco_pkg::cordic_stage_t pipe [N+1];
	nco_pkg::cordic_stage_t next [N];
	logic signed [W-1:0] x_in;
	logic signed [W-2:0] x_half;

	assign angle = phase[`NCO_PHASE_W-1 -: PW]; // top bits of the nco
	assign x_in = {{(W-`SAMPLE_W){beat.data[`SAMPLE_W-1]}}, beat.data};

	// quadrant fold so the residual starts in 0..90 degrees
	always_comb begin
		pre.valid = beat.valid;
		pre.z = {2'b00, angle[PW-3:0]};
		case (angle[PW-1 -: 2])
			2'b00: begin
				pre.x = x_in;
				pre.y = '0;
			end
			2'b01: begin
				pre.x = '0; // +90
				pre.y = x_in;
			end
			2'b10: begin
				pre.x = -x_in; // 180
				pre.y = '0;
			end
			default: begin
				pre.x = '0; // -90
				pre.y = -x_in;
			end
		endcase
	end

	// one micro-rotation per stage, sign of z picks direction
	always_comb begin
		for (int i = 0; i < N; i++) begin
			next[i].valid = pipe[i].valid;
			if (!pipe[i].z[PW-1]) begin
				next[i].x = pipe[i].x - ($signed(pipe[i].y) >>> i);
				next[i].y = pipe[i].y + ($signed(pipe[i].x) >>> i);
				next[i].z = pipe[i].z - ATAN[i];
			end else begin
				next[i].x = pipe[i].x + ($signed(pipe[i].y) >>> i);
				next[i].y = pipe[i].y - ($signed(pipe[i].x) >>> i);
				next[i].z = pipe[i].z + ATAN[i];
			end
		end
	end

	always_ff @(posedge ENC_CLK) begin
		pipe[0] <= pre;
		for (int i = 0; i < N; i++) begin
			pipe[i+1] <= next[i];
		end
		if (rst) begin
			for (int i = 0; i <= N; i++) begin
				pipe[i].valid <= 1'b0; // only the strobes
			end
		end
	end

	assign x_half = pipe[N].x[W-1:1]; // drop one bit of gain

	// saturate to the output word, gain left in
	always_comb begin
		result.valid = pipe[N].valid;
		if (x_half[W-2] != x_half[W-3]) begin
			result.data = x_half[W-2] ? 16'sh8000 : 16'sh7fff;
		end else begin
			result.data = x_half[`SAMPLE_W-1:0];
		end
	end

endmodule

//--- design/ddc_top.sv
`timescale 1ns/10ps

module ddc_top (
	input logic ENC_CLK,
	input logic rst,
	input stream_pkg::sample_t da,
	input nco_pkg::freq_t freq,
	input logic flagb,
	output stream_pkg::sample_t fd,
	output logic slwr,
	output logic slrd,
	output logic sloe,
	output logic [1:0] fifo_adr
);

	nco_pkg::phase_t phase;
	stream_pkg::sample_beat_t beat;
	stream_pkg::sample_beat_t result;
	stream_pkg::fifo_status_t status;
	stream_pkg::sample_t head;
	logic pop;
	logic clear;

	assign slrd = 1'b1; // write only
	assign sloe = 1'b1;
	assign fifo_adr = 2'b10; // ep6

	phase_accumulator phase_accumulator_inst (
		.ENC_CLK(ENC_CLK),
		.rst(rst),
		.freq(freq),
		.phase(phase)
	);

	adc_capture adc_capture_inst (
		.ENC_CLK(ENC_CLK),
		.rst(rst),
		.da(da),
		.status(status),
		.beat(beat)
	);

	cordic_rotator cordic_rotator_inst (
		.ENC_CLK(ENC_CLK),
		.rst(rst),
		.beat(beat),
		.phase(phase),
		.result(result)
	);

	sample_fifo sample_fifo_inst (
		.ENC_CLK(ENC_CLK),
		.rst(rst),
		.clear(clear),
		.wr(result),
		.pop(pop),
		.q(head),
		.status(status)
	);

	fx2_writer fx2_writer_inst (
		.ENC_CLK(ENC_CLK),
		.rst(rst),
		.status(status),
		.flagb(flagb),
		.head(head),
		.pop(pop),
		.clear(clear),
		.slwr(slwr),
		.fd(fd)
	);

endmodule

//--- design/fx2_writer.sv
`timescale 1ns/10ps

module fx2_writer (
	input logic ENC_CLK,
	input logic rst,
	input stream_pkg::fifo_status_t status,
	input logic flagb,
	input stream_pkg::sample_t head,
	output logic pop,
	output logic clear,
	output logic slwr,
	output stream_pkg::sample_t fd
);

	stream_pkg::fx2_state_e state;

	assign clear = (state == stream_pkg::FX2_CLEAR);

	// flagb low means the fx2 endpoint is full
	assign pop = (state == stream_pkg::FX2_RUN) && !status.empty && flagb;

	always_ff @(posedge ENC_CLK) begin
		if (rst) begin
			state <= stream_pkg::FX2_CLEAR;
			slwr <= 1'b1;
		end else begin
			case (state)
				stream_pkg::FX2_CLEAR: state <= stream_pkg::FX2_SETTLE;
				stream_pkg::FX2_SETTLE: state <= stream_pkg::FX2_RUN;
				stream_pkg::FX2_RUN: state <= stream_pkg::FX2_RUN;
				default: state <= stream_pkg::FX2_CLEAR;
			endcase
			slwr <= ~pop; // active low strobe
		end
	end

	// word lines up with the slwr low cycle
	always_ff @(posedge ENC_CLK) begin
		if (pop) begin
			fd <= head;
		end
	end

endmodule

//--- design/nco_pkg.sv
`include "nco_settings.svh"

package nco_pkg;

	// accumulator value, wraps modulo 2^32
	typedef logic [`NCO_PHASE_W-1:0] phase_t;

	// tuning word, one lsb is f_clk/2^32
	typedef logic [`NCO_PHASE_W-1:0] freq_t;

	// rotation angle, full scale is one turn
	typedef logic [`CORDIC_PHASE_W-1:0] cordic_phase_t;

	// carried from one rotator stage to the next
	typedef struct packed {
		logic signed [`CORDIC_XY_W-1:0] x;
		logic signed [`CORDIC_XY_W-1:0] y;
		cordic_phase_t z; // residual angle
		logic valid;
	} cordic_stage_t;

endpackage

//--- design/phase_accumulator.sv
`timescale 1ns/10ps

module phase_accumulator (
	input logic ENC_CLK,
	input logic rst,
	input nco_pkg::freq_t freq,
	output nco_pkg::phase_t phase
);

	nco_pkg::phase_t phase_q;

	always_ff @(posedge ENC_CLK) begin
		if (rst) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + freq; // wraps at 2^32
		end
	end

	assign phase = phase_q; // zero right after reset

endmodule

//--- design/sample_fifo.sv
`timescale 1ns/10ps
`include "nco_settings.svh"

module sample_fifo (
	input logic ENC_CLK,
	input logic rst,
	input logic clear,
	input stream_pkg::sample_beat_t wr,
	input logic pop,
	output stream_pkg::sample_t q,
	output stream_pkg::fifo_status_t status
);

	localparam logic [`FIFO_AW:0] DEPTH = `FIFO_DEPTH;

	stream_pkg::sample_t mem [`FIFO_DEPTH];
	logic [`FIFO_AW-1:0] wptr;
	logic [`FIFO_AW-1:0] rptr;
	logic [`FIFO_AW:0] count;
	logic do_wr;
	logic do_rd;

	assign status.empty = (count == '0);
	assign status.full = (count == DEPTH);
	assign do_wr = wr.valid && !status.full; // dropped when full
	assign do_rd = pop && !status.empty;
	assign q = mem[rptr]; // head word

	always_ff @(posedge ENC_CLK) begin
		if (do_wr) begin
			mem[wptr] <= wr.data;
		end
	end

	always_ff @(posedge ENC_CLK) begin
		if (rst || clear) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wptr <= wptr + 1'b1; // wraps, depth is a power of 2
			end
			if (do_rd) begin
				rptr <= rptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/stream_pkg.sv
`include "nco_settings.svh"

package stream_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// one word on the sample path with its strobe
	typedef struct packed {
		sample_t data;
		logic valid;
	} sample_beat_t;

	// sample fifo levels, seen by capture and writer
	typedef struct packed {
		logic empty;
		logic full;
	} fifo_status_t;

	// fx2 slave fifo writer
	typedef enum logic [1:0] {
		FX2_CLEAR,
		FX2_SETTLE,
		FX2_RUN
	} fx2_state_e;

endpackage

//--- flist.f
+incdir+include
design/nco_pkg.sv
design/stream_pkg.sv
design/phase_accumulator.sv
design/adc_capture.sv
design/cordic_rotator.sv
design/sample_fifo.sv
design/fx2_writer.sv
design/ddc_top.sv
tests/ddc_props.sv
tests/ddc_tb.sv

//--- include/nco_settings.svh
`ifndef NCO_SETTINGS_SVH
`define NCO_SETTINGS_SVH

// NCO
`define NCO_PHASE_W 32 // accumulator width
`define CORDIC_PHASE_W 16 // top phase bits fed to the rotator

// data path
`define SAMPLE_W 16 // adc and output word
`define CORDIC_XY_W 18 // headroom for cordic gain
`define CORDIC_STAGES 16 // shift-add iterations

// sample fifo
`define FIFO_DEPTH 512
`define FIFO_AW 9

`endif

//--- tests/ddc_props.sv
`timescale 1ns/10ps

module ddc_props (
	input logic ENC_CLK,
	input logic rst,
	input stream_pkg::fifo_status_t status,
	input stream_pkg::sample_beat_t result,
	input logic pop,
	input logic slwr
);

	// a strobe only follows a cycle with a word in the fifo
	slwr_needs_word: assert property (@(posedge ENC_CLK) disable iff (rst)
		!slwr |-> $past(!status.empty))
		else $error("slwr low after a cycle with the sample fifo empty");

	// a word offered while full must not be stored
	no_write_when_full: assert property (@(posedge ENC_CLK) disable iff (rst)
		status.full && result.valid && !pop |=> status.full)
		else $error("sample fifo took a write while full");

	reset_parks_slwr: assert property (@(posedge ENC_CLK)
		rst |=> slwr)
		else $error("slwr not high after reset");

endmodule

bind ddc_top ddc_props ddc_props_inst (
	.ENC_CLK(ENC_CLK),
	.rst(rst),
	.status(status),
	.result(result),
	.pop(pop),
	.slwr(slwr)
);

//--- tests/ddc_tb.sv
`timescale 1ns/10ps
`include "nco_settings.svh"

module ddc_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 4;
	localparam int RUN_CYCLES = 300;
	localparam int LEAD_CYCLES = 60;
	localparam int HOLD_CYCLES = 600; // well past a full fifo plus the pipeline
	localparam int DRAIN_CYCLES = 700;
	localparam int TAIL_CYCLES = 40;
	localparam int TOTAL_CYCLES = 5 * RST_CYCLES + 4 * RUN_CYCLES + RUN_CYCLES / 2
		+ LEAD_CYCLES + HOLD_CYCLES + DRAIN_CYCLES + TAIL_CYCLES;
	localparam nco_pkg::freq_t F_10MHZ = 32'h66666666; // 0.4 of a turn per clock
	localparam nco_pkg::freq_t F_SLOW = 32'd86; // about 0.5 Hz at 25 MHz
	localparam real PI = 3.14159265358979;

	typedef struct packed {
		stream_pkg::sample_t da;
		nco_pkg::cordic_phase_t ang;
	} pair_t;

	logic ENC_CLK;
	logic rst;
	stream_pkg::sample_t da;
	nco_pkg::freq_t freq;
	logic flagb;
	stream_pkg::sample_t fd;
	logic slwr;
	logic slrd;
	logic sloe;
	logic [1:0] fifo_adr;

	pair_t hist [$]; // what the rotator saw, one entry per cycle
	pair_t entry;
	nco_pkg::phase_t phase_m;
	logic [31:0] lfsr;
	logic rst_seen;
	logic flagb_seen;
	logic anchored;
	logic jump_ok;
	int since_rst;
	int match_idx;
	int checks;
	int errors;
	int words;
	int jumps;
	int mark;

	ddc_top ddc_top_inst (
		.ENC_CLK(ENC_CLK),
		.rst(rst),
		.da(da),
		.freq(freq),
		.flagb(flagb),
		.fd(fd),
		.slwr(slwr),
		.slrd(slrd),
		.sloe(sloe),
		.fifo_adr(fifo_adr)
	);

	always #(CLK_PERIOD / 2) ENC_CLK = ~ENC_CLK;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003; // x^32+x^22+x^2+x+1
		end
		return s >> 1;
	endfunction

	task automatic draw_sample(output stream_pkg::sample_t s);
		for (int b = 0; b < `SAMPLE_W; b++) begin
			lfsr = lfsr_step(lfsr);
			s[b] = lfsr[0];
		end
	endtask

	// atan(2^-i) rounded, 2^16 per turn
	function automatic int atan_step(input int i);
		real a;
		a = $atan(1.0 / (1 << i));
		return $rtoi(a * 65536.0 / (2.0 * PI) + 0.5);
	endfunction

	function automatic stream_pkg::sample_t cordic_ref(input stream_pkg::sample_t s,
			input nco_pkg::cordic_phase_t ang);
		logic signed [`CORDIC_XY_W-1:0] sx;
		logic signed [`CORDIC_XY_W-1:0] x;
		logic signed [`CORDIC_XY_W-1:0] y;
		logic signed [`CORDIC_XY_W-1:0] xs;
		logic signed [`CORDIC_XY_W-1:0] ys;
		logic signed [`CORDIC_XY_W-2:0] half;
		logic [`CORDIC_PHASE_W-1:0] z;
		logic [`CORDIC_PHASE_W-1:0] step;
		sx = s; // sign extended
		z = {2'b00, ang[`CORDIC_PHASE_W-3:0]};
		x = '0;
		y = '0;
		case (ang[`CORDIC_PHASE_W-1 -: 2])
			2'b00: x = sx;
			2'b01: y = sx; // quarter turn
			2'b10: x = -sx; // half turn
			default: y = -sx;
		endcase
		for (int i = 0; i < `CORDIC_STAGES; i++) begin
			step = atan_step(i);
			xs = x >>> i;
			ys = y >>> i;
			if (z[`CORDIC_PHASE_W-1]) begin
				x = x + ys; // residual negative, turn back
				y = y - xs;
				z = z + step;
			end else begin
				x = x - ys;
				y = y + xs;
				z = z - step;
			end
		end
		half = x[`CORDIC_XY_W-1:1];
		if (half[`CORDIC_XY_W-2] != half[`CORDIC_XY_W-3]) begin
			return half[`CORDIC_XY_W-2] ? 16'sh8000 : 16'sh7fff;
		end
		return half[`SAMPLE_W-1:0];
	endfunction

	function automatic stream_pkg::sample_t ref_at(input int i);
		return cordic_ref(hist[i].da, hist[i].ang);
	endfunction

	task automatic flag_failure(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic check_sample(input string name, input stream_pkg::sample_t got,
			input stream_pkg::sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// in order, one forward jump only while a gap is allowed
	task automatic match_word(input stream_pkg::sample_t word);
		int found;
		found = -1;
		if (!anchored || jump_ok) begin
			for (int i = anchored ? match_idx : 0; i < hist.size(); i++) begin
				if (found < 0 && ref_at(i) == word) found = i;
			end
			if (anchored && found > match_idx) begin
				jumps++;
				jump_ok = 1'b0;
			end
		end
		words++;
		if (found >= 0) begin
			anchored = 1'b1;
			match_idx = found + 1;
		end else if (anchored && match_idx < hist.size()) begin
			check_sample("fd", word, ref_at(match_idx));
			match_idx++;
		end else begin
			flag_failure($sformatf("fd word %h matches nothing in the sample history", word));
		end
	endtask

	task automatic drive_cycles(input int n);
		stream_pkg::sample_t s;
		repeat (n) begin
			@(posedge ENC_CLK);
			draw_sample(s);
			da <= s;
		end
	endtask

	task automatic apply_reset(input nco_pkg::freq_t f);
		rst <= 1'b1;
		freq <= f;
		drive_cycles(RST_CYCLES);
		rst <= 1'b0;
	endtask

	task automatic expect_words(input string test, input int since, input int least);
		if (words - since < least) begin
			flag_failure($sformatf("%s: only %0d words reached fd, expected at least %0d",
				test, words - since, least));
		end
	endtask

	// mirror of what the rotator sees after each edge
	always @(posedge ENC_CLK) begin
		rst_seen = rst;
		flagb_seen = flagb;
		if (rst) begin
			phase_m = '0;
			hist.delete();
			match_idx = 0;
			anchored = 1'b0;
			since_rst = 0;
		end else begin
			phase_m = phase_m + freq;
			entry.da = da; // value before this edge's update
			entry.ang = phase_m[`NCO_PHASE_W-1 -: `CORDIC_PHASE_W];
			hist.push_back(entry);
			if (since_rst < 16) since_rst++;
		end
	end

	always @(negedge ENC_CLK) begin
		check_bit("slrd", slrd, 1'b1);
		check_bit("sloe", sloe, 1'b1);
		check_bit("fifo_adr[1]", fifo_adr[1], 1'b1); // ep6
		check_bit("fifo_adr[0]", fifo_adr[0], 1'b0);
		if (rst_seen || since_rst < 4 || !flagb_seen) begin
			check_bit("slwr", slwr, 1'b1);
		end else if (slwr === 1'b0) begin
			match_word(fd);
		end
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 2);
		flag_failure("watchdog expired before the tests finished");
		$display("Verification failed");
		$finish;
	end

	initial begin
		ENC_CLK = 1'b0;
		rst = 1'b1;
		da = '0;
		freq = '0;
		flagb = 1'b1;
		lfsr = 32'he2612bb2;
		rst_seen = 1'b1;
		flagb_seen = 1'b1;
		anchored = 1'b0;
		jump_ok = 1'b0;
		since_rst = 0;
		match_idx = 0;
		phase_m = '0;
		checks = 0;
		errors = 0;
		words = 0;
		jumps = 0;
		drive_cycles(RST_CYCLES);
		rst <= 1'b0;

		mark = words; // phase stays 0, plain gain
		drive_cycles(RUN_CYCLES);
		expect_words("zero tuning word", mark, RUN_CYCLES - 40);

		apply_reset(F_10MHZ);
		mark = words;
		drive_cycles(RUN_CYCLES);
		expect_words("10 MHz tuning word", mark, RUN_CYCLES - 40);
		apply_reset(F_SLOW);
		mark = words;
		drive_cycles(RUN_CYCLES);
		expect_words("0.5 Hz tuning word", mark, RUN_CYCLES - 40);

		apply_reset(F_10MHZ); // fx2 side stalls
		mark = words;
		jumps = 0;
		drive_cycles(LEAD_CYCLES);
		flagb <= 1'b0;
		jump_ok = 1'b1;
		drive_cycles(HOLD_CYCLES);
		flagb <= 1'b1;
		drive_cycles(DRAIN_CYCLES);
		jump_ok = 1'b0;
		expect_words("back-pressure", mark, `FIFO_DEPTH + 100);
		if (jumps != 1) begin
			flag_failure($sformatf("back-pressure gave %0d forward jumps instead of one", jumps));
		end

		drive_cycles(RUN_CYCLES / 2); // reset lands mid-stream
		apply_reset(F_10MHZ);
		mark = words;
		drive_cycles(RUN_CYCLES);
		expect_words("restart after reset", mark, RUN_CYCLES - 40);
		drive_cycles(TAIL_CYCLES);

		$display("checks %0d errors %0d words %0d", checks, errors, words);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
